//--- Makefile
# Verilator build, run and lint for the QLA motor-axis core

TOP := tb_qla_top

.PHONY: all lint clean

# build and run, exit status follows the testbench
all:
	verilator --binary --timing --assert -f qla_top.f --top-module $(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f qla_top.f --top-module qla_top

clean:
	rm -rf obj_dir

//--- axis/axis_regs.sv
/*
 * axis registers
 * dac command per axis, adc feedback sampling,
 * and one readback word per axis chosen by the read offset
 */
`timescale 1ns/1ps
`default_nettype none

`include "qla_cfg.svh"

module axis_regs (
    input  wire                     sysclk,
    input  wire                     rst_n,
    input  wire [4:1]               axis_wen,       // one-hot per axis
    input  wire qla_pkg::axis_off_e axis_woff,
    input  wire qla_pkg::axis_off_e axis_roff,
    input  wire qla_pkg::reg_word_t reg_wdata,
    input  wire qla_pkg::cur_t      cur_fb [4:1],
    output qla_pkg::cur_t           dac_cmd [4:1],
    output qla_pkg::cur_t           cur_fb_q [4:1],
    output qla_pkg::reg_word_t      axis_rdata [4:1]
);

    // -------------------------------------
    // dac commands
    // -------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int n = 1; n <= `QLA_NUM_AXES; n++) begin
                dac_cmd[n] <= `QLA_DAC_MID;     // zero current
            end
        end else begin
            for (int n = 1; n <= `QLA_NUM_AXES; n++) begin
                if (axis_wen[n] && axis_woff == qla_pkg::OFF_DAC_CTRL)
                    dac_cmd[n] <= reg_wdata[15:0];
            end
        end
    end

    // adc feedback, sampled every cycle
    always_ff @(posedge sysclk) begin
        for (int n = 1; n <= `QLA_NUM_AXES; n++) begin
            cur_fb_q[n] <= cur_fb[n];
        end
    end

    // -------------------------------------
    // readback
    // -------------------------------------
    always_comb begin
        for (int n = 1; n <= `QLA_NUM_AXES; n++) begin
            if (axis_roff == qla_pkg::OFF_ADC_DATA)
                axis_rdata[n] = {16'h0000, cur_fb_q[n]};
            else
                axis_rdata[n] = {16'h0000, dac_cmd[n]};  // decoder zeroes bad offsets
        end
    end

endmodule

`default_nettype wire

//--- axis/safety_check.sv
/*
 * axis overcurrent monitor
 * trips when |feedback| exceeds 2x |command| plus margin for
 * QLA_SAFETY_COUNT consecutive cycles, holds until cleared
 */
`timescale 1ns/1ps
`default_nettype none

`include "qla_cfg.svh"

module safety_check (
    input  wire                sysclk,
    input  wire                rst_n,
    input  wire qla_pkg::cur_t cur_fb_q,
    input  wire qla_pkg::cur_t dac_cmd,
    input  wire                safety_clear,    // one-cycle pulse from board_regs
    output logic               amp_disable
);

    qla_pkg::safety_state_e state;
    logic [3:0]             cnt;        // overcurrent run length, count fits 4 bits
    logic [15:0]            fb_mag;     // distance from mid-scale
    logic [15:0]            cmd_mag;
    logic [17:0]            limit;      // 2x command + margin, no overflow
    logic                   over;

    // -------------------------------------
    // threshold compare
    // -------------------------------------
    assign fb_mag  = (cur_fb_q >= `QLA_DAC_MID) ? cur_fb_q - `QLA_DAC_MID
                                                : `QLA_DAC_MID - cur_fb_q;
    assign cmd_mag = (dac_cmd >= `QLA_DAC_MID) ? dac_cmd - `QLA_DAC_MID
                                               : `QLA_DAC_MID - dac_cmd;
    assign limit   = {1'b0, cmd_mag, 1'b0} + {2'b00, `QLA_SAFETY_MARGIN};
    assign over    = {2'b00, fb_mag} > limit;

    // -------------------------------------
    // debounce FSM
    // -------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state <= qla_pkg::SAFE_OK;
            cnt   <= '0;
        end else begin
            case (state)
                qla_pkg::SAFE_OK: begin
                    if (over) begin
                        state <= qla_pkg::SAFE_COUNTING;
                        cnt   <= 4'd1;      // first sample
                    end
                end
                qla_pkg::SAFE_COUNTING: begin
                    if (!over)
                        state <= qla_pkg::SAFE_OK;  // run broken
                    else if (cnt == 4'(`QLA_SAFETY_COUNT - 1))
                        state <= qla_pkg::SAFE_TRIPPED;
                    else
                        cnt <= cnt + 4'd1;
                end
                qla_pkg::SAFE_TRIPPED: begin
                    if (safety_clear)
                        state <= qla_pkg::SAFE_OK;
                end
                default: state <= qla_pkg::SAFE_OK;
            endcase
        end
    end

    assign amp_disable = (state == qla_pkg::SAFE_TRIPPED);

endmodule

`default_nettype wire

//--- common/qla_cfg.svh
/*
 * QLA configuration constants
 * address map sizes, reset values, safety limits and register bit positions
 */
`ifndef QLA_CFG_SVH
`define QLA_CFG_SVH

`define QLA_NUM_AXES        4
`define QLA_DAC_MID         16'h8000    // zero current command
`define QLA_SAFETY_COUNT    8           // consecutive overcurrent cycles to trip
`define QLA_SAFETY_MARGIN   16'h0100    // slack on top of 2x command

// status word fields
`define QLA_STAT_ID_LSB     28          // 4-bit board id
`define QLA_STAT_PWR        19
`define QLA_STAT_SAFE_LSB   8           // latched safety disables
`define QLA_STAT_FAULT_LSB  4
`define QLA_STAT_AMP_LSB    0           // effective amp enables

// masked write fields
`define QLA_WR_PWR_MASK     19
`define QLA_WR_PWR_VAL      18
`define QLA_WR_AMP_MASK_LSB 8
`define QLA_WR_AMP_VAL_LSB  0

// dout readback
`define QLA_DOUT_VALID      31
`define QLA_DOUT_BIDIR      30

`endif

//--- common/qla_pkg.sv
/*
 * QLA shared types
 * register bus words, current samples, and the enums used for
 * address decode and the per-axis safety FSM
 */
`default_nettype none

package qla_pkg;

    // -------------------------------------
    // bus and data words
    // -------------------------------------
    typedef logic [31:0] reg_word_t;    // one board register
    typedef logic [15:0] reg_addr_t;    // quadlet address
    typedef logic [15:0] cur_t;         // offset binary, mid-scale is zero amps

    // addr[15:12]
    typedef enum logic [3:0] {
        SPACE_MAIN     = 4'd0,          // board and axis registers
        SPACE_HUB      = 4'd1,
        SPACE_PROM     = 4'd2,
        SPACE_PROM_QLA = 4'd3,
        SPACE_ETH      = 4'd4,
        SPACE_FW       = 4'd5,
        SPACE_DS       = 4'd6           // 1-wire, not served here
    } addr_space_e;

    // channel 0 offsets, addr[3:0]
    typedef enum logic [3:0] {
        BOARD_STATUS = 4'd0,
        BOARD_DOUT   = 4'd1
    } board_off_e;

    // offsets within axis channels 1..4
    typedef enum logic [3:0] {
        OFF_ADC_DATA = 4'd0,            // sampled feedback
        OFF_DAC_CTRL = 4'd1             // current command
    } axis_off_e;

    // overcurrent monitor
    typedef enum logic [1:0] {
        SAFE_OK,
        SAFE_COUNTING,                  // overcurrent seen, not yet long enough
        SAFE_TRIPPED                    // amp held off until cleared
    } safety_state_e;

endpackage

`default_nettype wire

//--- qla_top.f
+incdir+common
common/qla_pkg.sv
src/reg_bus_decode.sv
src/board_regs.sv
src/dout_ctrl.sv
axis/axis_regs.sv
axis/safety_check.sv
src/qla_top.sv
sim/tb_qla_top.sv

//--- sim/tb_qla_top.sv
/*
 * testbench for the QLA motor-axis core
 * directed tests over the register bus, checked against a small
 * model of the enable, safety latch and readback rules
 */
`timescale 1ns/1ps
`default_nettype none

`include "qla_cfg.svh"

module tb_qla_top;

    localparam int CLK_PERIOD  = 100;
    localparam int TEST_CYCLES = 200;   // all tests take about 190 cycles

    logic        sysclk;
    logic        rst_n;
    logic        reg_wen;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic [15:0] reg_raddr;
    logic [31:0] reg_rdata;
    logic [3:0]  board_id;
    logic [4:1]  amp_fault;
    logic [15:0] cur_fb [4:1];
    logic        dout_bidir;
    logic [15:0] dac_cmd [4:1];
    logic        pwr_enable;
    logic [4:1]  amp_enable;
    logic [4:1]  dout_pins;

    // reference model
    logic        model_pwr;
    logic [4:1]  model_amp;             // stored enables
    logic [4:1]  model_dis;             // safety latches
    logic [15:0] model_cmd [4:1];
    integer      seed;

    qla_top dut (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .reg_wen    (reg_wen),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata),
        .reg_raddr  (reg_raddr),
        .reg_rdata  (reg_rdata),
        .board_id   (board_id),
        .amp_fault  (amp_fault),
        .cur_fb     (cur_fb),
        .dout_bidir (dout_bidir),
        .dac_cmd    (dac_cmd),
        .pwr_enable (pwr_enable),
        .amp_enable (amp_enable),
        .dout_pins  (dout_pins)
    );

    initial begin
        sysclk = 1'b0;
        forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
    end

    // watchdog, twice the expected run length
    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end

    // ----------------------------------------
    // checks and model
    // ----------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [4:1] expected_amp();
        return model_amp & {4{model_pwr}} & ~model_dis;    // gated by power and latch
    endfunction

    function automatic logic [31:0] expected_status();
        logic [31:0] w;
        w = '0;
        w[`QLA_STAT_ID_LSB +: 4]    = board_id;
        w[`QLA_STAT_PWR]            = model_pwr;
        w[`QLA_STAT_SAFE_LSB +: 4]  = model_dis;
        w[`QLA_STAT_FAULT_LSB +: 4] = amp_fault;
        w[`QLA_STAT_AMP_LSB +: 4]   = expected_amp();
        return w;
    endfunction

    function automatic logic [31:0] enable_word(input logic pm, input logic pv,
                                                input logic [3:0] am, input logic [3:0] av);
        logic [31:0] w;
        w = '0;
        w[`QLA_WR_PWR_MASK]          = pm;
        w[`QLA_WR_PWR_VAL]           = pv;
        w[`QLA_WR_AMP_MASK_LSB +: 4] = am;
        w[`QLA_WR_AMP_VAL_LSB +: 4]  = av;
        return w;
    endfunction

    function automatic logic [15:0] axis_addr(input int n, input logic [3:0] off);
        return {8'h00, 4'(n), off};     // main space, channel n
    endfunction

    // ----------------------------------------
    // bus and stimulus tasks
    // ----------------------------------------
    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge sysclk);
        reg_wen   <= 1'b1;
        reg_waddr <= addr;
        reg_wdata <= data;
        @(posedge sysclk);              // write lands here
        reg_wen   <= 1'b0;
    endtask

    task automatic bus_read_check(input logic [15:0] addr, input logic [31:0] exp,
                                  input string name);
        @(posedge sysclk);
        reg_raddr <= addr;
        @(posedge sysclk);              // rdata registered
        @(negedge sysclk);
        check_value(name, reg_rdata, exp);
    endtask

    task automatic apply_reset(input logic bidir);
        rst_n      <= 1'b0;
        dout_bidir <= bidir;
        repeat (5) @(posedge sysclk);
        rst_n      <= 1'b1;
        model_pwr = 1'b0;
        model_amp = '0;
        model_dis = '0;
        for (int n = 1; n <= `QLA_NUM_AXES; n++)
            model_cmd[n] = `QLA_DAC_MID;
    endtask

    task automatic check_board();
        @(negedge sysclk);
        check_value("pwr_enable", 32'(pwr_enable), 32'(model_pwr));
        check_value("amp_enable", 32'(amp_enable), 32'(expected_amp()));
        bus_read_check(16'h0000, expected_status(), "status");
    endtask

    task automatic write_enables(input logic pm, input logic pv,
                                 input logic [3:0] am, input logic [3:0] av);
        bus_write(16'h0000, enable_word(pm, pv, am, av));
        if (pm)
            model_pwr = pv;
        if (pm && pv)
            model_dis = '0;             // power on clears every latch
        for (int n = 1; n <= `QLA_NUM_AXES; n++) begin
            if (am[n-1]) begin
                model_amp[n] = av[n-1];
                if (av[n-1])
                    model_dis[n] = 1'b0;
            end
        end
        check_board();
    endtask

    // drive one axis for a number of cycles, then back to zero current
    task automatic hold_feedback(input int axis, input logic [15:0] value, input int cycles);
        @(posedge sysclk);
        cur_fb[axis] <= value;
        repeat (cycles) @(posedge sysclk);
        cur_fb[axis] <= `QLA_DAC_MID;
        repeat (3) @(posedge sysclk);   // monitor settles
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic test_reset_values();
        @(negedge sysclk);
        check_value("pwr_enable", 32'(pwr_enable), 32'h0);
        check_value("amp_enable", 32'(amp_enable), 32'h0);
        check_value("dout_pins", 32'(dout_pins), 32'h0);
        check_value("reg_rdata", reg_rdata, 32'h0);
        for (int n = 1; n <= `QLA_NUM_AXES; n++)
            check_value($sformatf("dac_cmd[%0d]", n), 32'(dac_cmd[n]), 32'h8000);
        bus_read_check(16'h0000, expected_status(), "status");  // id and faults only
    endtask

    task automatic test_dac_commands();
        logic [31:0] word;
        for (int n = 1; n <= `QLA_NUM_AXES; n++) begin
            word = $random(seed);       // upper half must be ignored
            bus_write(axis_addr(n, qla_pkg::OFF_DAC_CTRL), word);
            model_cmd[n] = word[15:0];
            @(negedge sysclk);
            for (int m = 1; m <= `QLA_NUM_AXES; m++)
                check_value($sformatf("dac_cmd[%0d]", m), 32'(dac_cmd[m]), 32'(model_cmd[m]));
            bus_read_check(axis_addr(n, qla_pkg::OFF_DAC_CTRL), {16'h0000, word[15:0]},
                           $sformatf("dac readback %0d", n));
        end
    endtask

    task automatic test_feedback();
        logic [15:0] fb [4:1];
        @(posedge sysclk);
        for (int n = 1; n <= `QLA_NUM_AXES; n++) begin
            fb[n] = 16'h7f80 + 16'($random(seed) & 32'h00ff);   // near zero, no overcurrent
            cur_fb[n] <= fb[n];
        end
        repeat (2) @(posedge sysclk);
        for (int n = 1; n <= `QLA_NUM_AXES; n++)
            bus_read_check(axis_addr(n, qla_pkg::OFF_ADC_DATA), {16'h0000, fb[n]},
                           $sformatf("adc readback %0d", n));
        // unmapped spaces, channels, offsets
        bus_read_check(16'h1000, 32'h0, "hub space read");
        bus_read_check(16'h5010, 32'h0, "fw space read");
        bus_read_check(16'h0050, 32'h0, "channel 5 read");
        bus_read_check(16'h0012, 32'h0, "axis 1 offset 2 read");
        bus_read_check(16'h0003, 32'h0, "board offset 3 read");
    endtask

    task automatic test_enables();
        write_enables(1'b1, 1'b1, 4'b0000, 4'b0000);    // power only
        write_enables(1'b0, 1'b0, 4'b0101, 4'b0101);
        write_enables(1'b0, 1'b1, 4'b1111, 4'b1010);    // power value without mask
        write_enables(1'b0, 1'b0, 4'b0010, 4'b0000);
        write_enables(1'b1, 1'b0, 4'b0000, 4'b0000);    // power off gates all amps
        write_enables(1'b1, 1'b1, 4'b0000, 4'b1111);    // stored enables return
    endtask

    task automatic test_safety();
        write_enables(1'b1, 1'b1, 4'b1111, 4'b1111);
        bus_write(axis_addr(2, qla_pkg::OFF_DAC_CTRL), 32'h0000_8400);  // limit 0x900
        model_cmd[2] = 16'h8400;
        @(negedge sysclk);
        check_value("dac_cmd[2]", 32'(dac_cmd[2]), 32'(model_cmd[2]));
        hold_feedback(2, 16'h9000, `QLA_SAFETY_COUNT - 1);  // too short to trip
        check_board();
        hold_feedback(2, 16'h9000, `QLA_SAFETY_COUNT + 2);
        model_dis[2] = 1'b1;
        check_board();
        write_enables(1'b0, 1'b0, 4'b0010, 4'b0010);    // amp 2 on clears its latch
        // negative side on axis 4, cleared by power on
        bus_write(axis_addr(4, qla_pkg::OFF_DAC_CTRL), 32'h0000_8000);
        model_cmd[4] = 16'h8000;
        @(negedge sysclk);
        check_value("dac_cmd[4]", 32'(dac_cmd[4]), 32'(model_cmd[4]));
        hold_feedback(4, 16'h7e00, `QLA_SAFETY_COUNT + 2);
        model_dis[4] = 1'b1;
        check_board();
        write_enables(1'b1, 1'b1, 4'b0000, 4'b0000);
    endtask

    task automatic test_dout();
        logic [31:0] word;
        for (int pass = 0; pass < 2; pass++) begin
            @(posedge sysclk);
            apply_reset(1'(pass));      // strap sampled after reset
            for (int k = 0; k < 3; k++) begin
                word = $random(seed);
                bus_write(16'h0001, word);
                @(negedge sysclk);
                check_value("dout_pins", 32'(dout_pins), 32'(word[3:0] ^ {4{dout_bidir}}));
                bus_read_check(16'h0001, {1'b1, dout_bidir, 26'h0, word[3:0]},
                               "dout readback");
            end
        end
    endtask

    initial begin
        seed       = 58;
        rst_n      <= 1'b0;
        reg_wen    <= 1'b0;
        reg_waddr  <= '0;
        reg_wdata  <= '0;
        reg_raddr  <= '0;
        board_id   <= 4'ha;
        amp_fault  <= 4'b0110;
        dout_bidir <= 1'b0;
        for (int n = 1; n <= `QLA_NUM_AXES; n++)
            cur_fb[n] <= `QLA_DAC_MID;
        apply_reset(1'b0);
        test_reset_values();
        test_dac_commands();
        test_feedback();
        test_enables();
        test_safety();
        test_dout();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/board_regs.sv
/*
 * board register, channel 0
 * masked power and amp enable writes, status word with id,
 * faults and safety latches, and safety latch clear pulses
 */
`timescale 1ns/1ps
`default_nettype none

`include "qla_cfg.svh"

module board_regs (
    input  wire                     sysclk,
    input  wire                     rst_n,
    input  wire                     board_wen,
    input  wire qla_pkg::reg_word_t reg_wdata,
    input  wire [3:0]               board_id,
    input  wire [4:1]               amp_fault,      // amplifier fault inputs
    input  wire [4:1]               amp_disable,    // from the safety checks
    output qla_pkg::reg_word_t      board_rdata,
    output logic                    pwr_enable,
    output logic [4:1]              amp_enable,
    output logic [4:1]              safety_clear
);

    logic       pwr_q;      // board power
    logic [4:1] amp_q;      // stored amp enables, before gating
    logic       pwr_set;    // this write turns power on
    logic [4:1] amp_set;    // this write turns amp n on

    // -------------------------------------
    // masked write decode
    // -------------------------------------
    always_comb begin
        pwr_set = board_wen && reg_wdata[`QLA_WR_PWR_MASK]
                  && reg_wdata[`QLA_WR_PWR_VAL];
        for (int n = 1; n <= `QLA_NUM_AXES; n++) begin
            amp_set[n] = board_wen && reg_wdata[`QLA_WR_AMP_MASK_LSB + n - 1]
                         && reg_wdata[`QLA_WR_AMP_VAL_LSB + n - 1];
        end
    end

    // power on clears every latch, amp on clears its own
    assign safety_clear = {4{pwr_set}} | amp_set;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            pwr_q <= 1'b0;
            amp_q <= '0;
        end else if (board_wen) begin
            if (reg_wdata[`QLA_WR_PWR_MASK])
                pwr_q <= reg_wdata[`QLA_WR_PWR_VAL];
            for (int n = 1; n <= `QLA_NUM_AXES; n++) begin
                if (reg_wdata[`QLA_WR_AMP_MASK_LSB + n - 1])
                    amp_q[n] <= reg_wdata[`QLA_WR_AMP_VAL_LSB + n - 1];
            end
        end
    end

    // -------------------------------------
    // outputs
    // -------------------------------------
    assign pwr_enable = pwr_q;
    // amp only on with power up and no safety trip
    assign amp_enable = amp_q & {4{pwr_q}} & ~amp_disable;

    // status word
    always_comb begin
        board_rdata = '0;
        board_rdata[`QLA_STAT_ID_LSB +: 4]    = board_id;
        board_rdata[`QLA_STAT_PWR]            = pwr_q;
        board_rdata[`QLA_STAT_SAFE_LSB +: 4]  = amp_disable;
        board_rdata[`QLA_STAT_FAULT_LSB +: 4] = amp_fault;
        board_rdata[`QLA_STAT_AMP_LSB +: 4]   = amp_enable;   // effective, not stored
    end

endmodule

`default_nettype wire

//--- src/dout_ctrl.sv
/*
 * digital output control
 * 4-bit output register, pin polarity set by the bidir strap
 */
`timescale 1ns/1ps
`default_nettype none

`include "qla_cfg.svh"

module dout_ctrl (
    input  wire                     sysclk,
    input  wire                     rst_n,
    input  wire                     dout_wen,
    input  wire qla_pkg::reg_word_t reg_wdata,
    input  wire                     dout_bidir,     // strap, 1 = inverting buffers
    output qla_pkg::reg_word_t      dout_rdata,
    output logic [4:1]              dout_pins
);

    logic [3:0] dout_q;
    logic       cfg_valid;  // strap has been sampled
    logic       cfg_bidir;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            dout_q    <= '0;
            cfg_valid <= 1'b0;
            cfg_bidir <= 1'b0;
        end else begin
            if (!cfg_valid) begin
                cfg_valid <= 1'b1;          // first cycle out of reset
                cfg_bidir <= dout_bidir;
            end
            if (dout_wen)
                dout_q <= reg_wdata[3:0];
        end
    end

    // bidir hardware inverts, so undo it here
    assign dout_pins = dout_q ^ {4{cfg_bidir}};

    always_comb begin
        dout_rdata = '0;
        dout_rdata[3:0]             = dout_q;
        dout_rdata[`QLA_DOUT_VALID] = cfg_valid;
        dout_rdata[`QLA_DOUT_BIDIR] = cfg_bidir;
    end

endmodule

`default_nettype wire

//--- src/qla_top.sv
/*
 * QLA motor-axis controller core
 * register bus decode, board control, digital outputs,
 * four axis command/feedback channels and their overcurrent monitors
 */
`timescale 1ns/1ps
`default_nettype none

`include "qla_cfg.svh"

module qla_top (
    input  wire                     sysclk,
    input  wire                     rst_n,
    // host register bus
    input  wire                     reg_wen,
    input  wire qla_pkg::reg_addr_t reg_waddr,
    input  wire qla_pkg::reg_word_t reg_wdata,
    input  wire qla_pkg::reg_addr_t reg_raddr,
    output qla_pkg::reg_word_t      reg_rdata,
    // board side
    input  wire [3:0]               board_id,
    input  wire [4:1]               amp_fault,
    input  wire qla_pkg::cur_t      cur_fb [4:1],   // adc current feedback
    input  wire                     dout_bidir,     // hardware strap
    output qla_pkg::cur_t           dac_cmd [4:1],  // dac current command
    output logic                    pwr_enable,
    output logic [4:1]              amp_enable,
    output logic [4:1]              dout_pins
);

    // -------------------------------------
    // internal wiring
    // -------------------------------------
    logic                board_wen;
    logic                dout_wen;
    logic [4:1]          axis_wen;
    qla_pkg::axis_off_e  axis_woff;
    qla_pkg::axis_off_e  axis_roff;
    qla_pkg::reg_word_t  board_rdata;
    qla_pkg::reg_word_t  dout_rdata;
    qla_pkg::reg_word_t  axis_rdata [4:1];
    qla_pkg::cur_t       cur_fb_q [4:1];     // registered feedback
    logic [4:1]          amp_disable;        // safety latch outputs
    logic [4:1]          safety_clear;       // latch clear pulses

    reg_bus_decode u_decode (
        .sysclk(sysclk),
        .rst_n(rst_n),
        .reg_wen(reg_wen),
        .reg_waddr(reg_waddr),
        .reg_raddr(reg_raddr),
        .board_rdata(board_rdata),
        .dout_rdata(dout_rdata),
        .axis_rdata(axis_rdata),
        .board_wen(board_wen),
        .dout_wen(dout_wen),
        .axis_wen(axis_wen),
        .axis_woff(axis_woff),
        .axis_roff(axis_roff),
        .reg_rdata(reg_rdata)
    );

    board_regs u_board (
        .sysclk(sysclk),
        .rst_n(rst_n),
        .board_wen(board_wen),
        .reg_wdata(reg_wdata),
        .board_id(board_id),
        .amp_fault(amp_fault),
        .amp_disable(amp_disable),
        .board_rdata(board_rdata),
        .pwr_enable(pwr_enable),
        .amp_enable(amp_enable),
        .safety_clear(safety_clear)
    );

    dout_ctrl u_dout (
        .sysclk(sysclk),
        .rst_n(rst_n),
        .dout_wen(dout_wen),
        .reg_wdata(reg_wdata),
        .dout_bidir(dout_bidir),
        .dout_rdata(dout_rdata),
        .dout_pins(dout_pins)
    );

    axis_regs u_axis (
        .sysclk(sysclk),
        .rst_n(rst_n),
        .axis_wen(axis_wen),
        .axis_woff(axis_woff),
        .axis_roff(axis_roff),
        .reg_wdata(reg_wdata),
        .cur_fb(cur_fb),
        .dac_cmd(dac_cmd),
        .cur_fb_q(cur_fb_q),
        .axis_rdata(axis_rdata)
    );

    // one overcurrent monitor per axis
    for (genvar n = 1; n <= `QLA_NUM_AXES; n++) begin : g_safety
        safety_check u_safe (
            .sysclk(sysclk),
            .rst_n(rst_n),
            .cur_fb_q(cur_fb_q[n]),
            .dac_cmd(dac_cmd[n]),
            .safety_clear(safety_clear[n]),
            .amp_disable(amp_disable[n])
        );
    end

endmodule

`default_nettype wire

//--- src/reg_bus_decode.sv
/*
 * register bus decoder
 * splits write addresses into per-block strobes and
 * registers the read word selected by the read address
 */
`timescale 1ns/1ps
`default_nettype none

`include "qla_cfg.svh"

module reg_bus_decode (
    input  wire                     sysclk,
    input  wire                     rst_n,
    input  wire                     reg_wen,
    input  wire qla_pkg::reg_addr_t reg_waddr,
    input  wire qla_pkg::reg_addr_t reg_raddr,
    input  wire qla_pkg::reg_word_t board_rdata,
    input  wire qla_pkg::reg_word_t dout_rdata,
    input  wire qla_pkg::reg_word_t axis_rdata [4:1],
    output logic                    board_wen,
    output logic                    dout_wen,
    output logic [4:1]              axis_wen,
    output qla_pkg::axis_off_e      axis_woff,
    output qla_pkg::axis_off_e      axis_roff,
    output qla_pkg::reg_word_t      reg_rdata
);

    qla_pkg::addr_space_e w_space, r_space;
    qla_pkg::board_off_e  w_boff, r_boff;
    logic [3:0]           w_chan, r_chan;   // addr[7:4]
    logic                 w_main;           // write hits main space
    qla_pkg::reg_word_t   rdata_next;

    // -------------------------------------
    // write side, same-cycle strobes
    // -------------------------------------
    assign w_space   = qla_pkg::addr_space_e'(reg_waddr[15:12]);
    assign w_chan    = reg_waddr[7:4];
    assign w_boff    = qla_pkg::board_off_e'(reg_waddr[3:0]);
    assign axis_woff = qla_pkg::axis_off_e'(reg_waddr[3:0]);   // axis_regs checks it
    assign w_main    = reg_wen && (w_space == qla_pkg::SPACE_MAIN);

    assign board_wen = w_main && (w_chan == 4'd0) && (w_boff == qla_pkg::BOARD_STATUS);
    assign dout_wen  = w_main && (w_chan == 4'd0) && (w_boff == qla_pkg::BOARD_DOUT);

    always_comb begin
        for (int n = 1; n <= `QLA_NUM_AXES; n++) begin
            axis_wen[n] = w_main && (w_chan == 4'(n));
        end
    end

    // -------------------------------------
    // read side
    // -------------------------------------
    assign r_space   = qla_pkg::addr_space_e'(reg_raddr[15:12]);
    assign r_chan    = reg_raddr[7:4];
    assign r_boff    = qla_pkg::board_off_e'(reg_raddr[3:0]);
    assign axis_roff = qla_pkg::axis_off_e'(reg_raddr[3:0]);

    always_comb begin
        rdata_next = '0;                    // unmapped reads as zero
        if (r_space == qla_pkg::SPACE_MAIN) begin
            if (r_chan == 4'd0) begin
                if (r_boff == qla_pkg::BOARD_STATUS)
                    rdata_next = board_rdata;
                else if (r_boff == qla_pkg::BOARD_DOUT)
                    rdata_next = dout_rdata;
            end else if (axis_roff == qla_pkg::OFF_ADC_DATA ||
                         axis_roff == qla_pkg::OFF_DAC_CTRL) begin
                for (int n = 1; n <= `QLA_NUM_AXES; n++) begin
                    if (r_chan == 4'(n))
                        rdata_next = axis_rdata[n];
                end
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n)
            reg_rdata <= '0;
        else
            reg_rdata <= rdata_next;        // one cycle read latency
    end

endmodule

`default_nettype wire
